/* compile.f */
src/execPkg.sv
src/mulPipe.sv
src/divIter.sv
src/execControl.sv
src/mulDivUnit.sv
sim/tbClock.sv
sim/mulDivUnit_asserts.sv
sim/mulDivTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build and run the mulDivUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module mulDivTb -Mdir obj_dir -o simv \
    -f compile.f > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulator exited with status $simStatus"
    exit 1
fi

echo "Simulation passed"
exit 0

/* sim/mulDivTb.sv */
`timescale 1ns/1ps

module mulDivTb import execPkg::*; ();

    localparam int opBudget = 32 + 64 + 24 + 12 + 64 + 2 * 13 + 8 * 5;
    localparam int wdCycles = opBudget * (divSteps + mulLatency + 10) + 100;

    logic  clk;
    logic  rst;
    logic  en;
    logic  inValid;
    OpCode inOp;
    Word   srcA;
    Word   srcB;
    Tag    inTag;
    SqN    inSqN;
    logic  branchTaken;
    SqN    branchSqN;
    logic  busy;
    logic  outValid;
    Tag    outTag;
    SqN    outSqN;
    Word   outResult;

    // Scoreboard, indexed by tag
    logic expValid  [64];
    logic expKilled [64];
    logic expDiv    [64];
    SqN   expSqN    [64];
    Word  expRes    [64];
    int   expAccept [64];
    Tag   mulOrder [$];

    logic [31:0] rngState;
    Tag   nextTag;
    SqN   nextSqN;
    int   edgeCnt;
    int   pendingCnt;
    int   killedCnt;
    logic divPending;
    int   divAcceptEdge;
    Word  corners [4];

    tbClock i_tbClock (.clk, .rst);

    mulDivUnit i_mulDivUnit (
        .clk, .rst, .en, .inValid, .inOp, .srcA, .srcB, .inTag, .inSqN,
        .branchTaken, .branchSqN,
        .busy, .outValid, .outTag, .outSqN, .outResult
    );

    bind mulDivUnit mulDivUnit_asserts i_asserts (
        .clk, .rst, .en, .inValid, .inOp, .branchTaken, .busy, .mulStart, .outValid
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic Word randWord();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    function automatic logic youngerThan(input SqN item, input SqN br);
        logic signed [6:0] d;
        d = item - br;  // Wrapping age
        return d > 0;
    endfunction

    // RISC-V M extension results
    function automatic Word refResult(input OpCode op, input Word a, input Word b);
        longint      sa;
        longint      sb;
        logic [63:0] p;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (op)
            MulMul:   p = 64'(sa * sb);
            MulMulh:  p = 64'(sa * sb);
            MulMulsu: p = 64'(sa * longint'({32'b0, b}));
            MulMulu:  p = {32'b0, a} * {32'b0, b};
            default:  p = '0;
        endcase
        case (op)
            MulMul:  return p[31:0];
            DivDiv: begin
                if (b == '0) return '1;
                if (a == 32'h8000_0000 && b == '1) return 32'h8000_0000;
                return Word'(sa / sb);
            end
            DivDivu: return (b == '0) ? '1 : a / b;
            DivRem: begin
                if (b == '0) return a;
                if (a == 32'h8000_0000 && b == '1) return '0;
                return Word'(sa % sb);
            end
            DivRemu: return (b == '0) ? a : a % b;
            default: return p[63:32];
        endcase
    endfunction

    task automatic failNow(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic checkResult(input string name, input Word exp, input Word got);
        if (got !== exp) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, got);
            failNow("Result mismatch");
        end
    endtask

    task automatic checkTag(input string name, input Tag exp, input Tag got);
        if (got !== exp) begin
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, got);
            failNow("Tag mismatch");
        end
    endtask

    task automatic checkSqN(input string name, input SqN exp, input SqN got);
        if (got !== exp) begin
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, got);
            failNow("Sequence number mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic applyBranch(input SqN br);
        Tag keep [$];
        for (int t = 0; t < 64; t++) begin
            if (expValid[t] && youngerThan(expSqN[t], br)) begin
                expValid[t]  = 1'b0;
                expKilled[t] = 1'b1;
                pendingCnt--;
                killedCnt++;
                if (expDiv[t]) divPending = 1'b0;
            end
        end
        foreach (mulOrder[i]) if (expValid[mulOrder[i]]) keep.push_back(mulOrder[i]);
        mulOrder = keep;
    endtask

    task automatic sendOp(input OpCode op, input Word a, input Word b,
                          input logic taken, input SqN br);
        Tag t;
        @(posedge clk);
        #2;
        t = nextTag;
        if (expValid[t]) failNow("A tag was reused while still in flight");
        en          = 1'b1;
        inValid     = 1'b1;
        inOp        = op;
        srcA        = a;
        srcB        = b;
        inTag       = t;
        inSqN       = nextSqN;
        branchTaken = taken;
        branchSqN   = br;
        expValid[t]  = 1'b1;
        expKilled[t] = 1'b0;
        expDiv[t]    = op[2];
        expSqN[t]    = nextSqN;
        expRes[t]    = refResult(op, a, b);
        expAccept[t] = edgeCnt + 1;  // Sampled at the next edge
        if (op[2]) begin
            divPending    = 1'b1;
            divAcceptEdge = edgeCnt + 1;
        end else begin
            mulOrder.push_back(t);
        end
        pendingCnt++;
        nextTag = nextTag + 1'b1;
        nextSqN = nextSqN + 1'b1;
        if (taken) applyBranch(br);
    endtask

    task automatic idle();
        @(posedge clk);
        #2;
        en          = 1'b1;
        inValid     = 1'b0;
        branchTaken = 1'b0;
    endtask

    task automatic drain();
        idle();
        while (pendingCnt != 0) @(negedge clk);
    endtask

    task automatic randMulOp(input logic taken, input SqN br);
        Word r;
        r = randWord();
        sendOp(OpCode'({1'b0, r[1:0]}), randWord(), randWord(), taken, br);
    endtask

    ////////////////////////////////////////////////////////////
    // Comparison and watchdog
    ////////////////////////////////////////////////////////////

    always @(posedge clk) edgeCnt <= edgeCnt + 1;

    always @(negedge clk) begin
        if (rst && outValid) begin
            if (!expValid[outTag]) begin
                if (expKilled[outTag]) failNow("A killed tag was written back");
                else failNow("A tag that was never accepted was written back");
            end
            checkSqN("outSqN", expSqN[outTag], outSqN);
            checkResult("outResult", expRes[outTag], outResult);
            if (expDiv[outTag]) begin
                divPending = 1'b0;
            end else begin
                checkTag("outTag", mulOrder[0], outTag);  // Multiplies stay in order
                void'(mulOrder.pop_front());
                if (edgeCnt - expAccept[outTag] != mulLatency)
                    failNow("A multiply result came out at the wrong latency");
            end
            expValid[outTag] = 1'b0;
            pendingCnt--;
        end
        if (rst && divPending && edgeCnt >= divAcceptEdge && !busy)
            failNow("busy dropped while a divide was still outstanding");
    end

    initial begin
        repeat (wdCycles) @(posedge clk);
        $display("Timeout, the cluster stopped producing results");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        en = 1'b0;
        inValid = 1'b0;
        inOp = MulMul;
        srcA = '0;
        srcB = '0;
        inTag = '0;
        inSqN = '0;
        branchTaken = 1'b0;
        branchSqN = '0;
        rngState = 32'h09ed_fa27;
        nextTag = '0;
        nextSqN = '0;
        edgeCnt = 0;
        pendingCnt = 0;
        killedCnt = 0;
        divPending = 1'b0;
        divAcceptEdge = 0;
        corners = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000};
        for (int t = 0; t < 64; t++) begin
            expValid[t]  = 1'b0;
            expKilled[t] = 1'b0;
            expDiv[t]    = 1'b0;
        end
        wait (rst === 1'b1);
        repeat (2) @(posedge clk);

        for (int i = 0; i < 32; i++) randMulOp(1'b0, '0);  // Random multiplies
        drain();
        for (int op = 0; op < 4; op++)
            for (int ia = 0; ia < 4; ia++)
                for (int ib = 0; ib < 4; ib++)
                    sendOp(OpCode'(3'(op)), corners[ia], corners[ib], 1'b0, '0);
        drain();

        // Offer with en low, must not come out
        @(posedge clk);
        #2;
        en = 1'b0;
        inValid = 1'b1;
        inTag = nextTag;
        drain();

        for (int i = 0; i < 24; i++) randMulOp(1'b0, '0);  // Back-to-back stream
        drain();

        for (int i = 0; i < 12; i++) begin
            sendOp(OpCode'({1'b1, i[1:0]}),
                   randWord(), randWord() >> (randWord() % 28), 1'b0, '0);
            drain();
        end
        for (int op = 4; op < 8; op++)
            for (int ia = 0; ia < 4; ia++)
                for (int ib = 0; ib < 4; ib++) begin
                    sendOp(OpCode'(3'(op)), corners[ia], corners[ib], 1'b0, '0);
                    drain();
                end

        // Divide finishing under a run of multiplies
        for (int r = 0; r < 2; r++) begin
            sendOp(OpCode'(3'(4 + r)), randWord(), randWord() >> 20, 1'b0, '0);
            idle();
            repeat (20 + 4 * r) @(posedge clk);
            for (int i = 0; i < 12; i++) randMulOp(1'b0, '0);
            drain();
        end

        // Taken branch with a random SqN around the burst
        for (int r = 0; r < 8; r++) begin
            SqN base;
            SqN br;
            base = nextSqN;
            br   = base - 7'd1 + SqN'(randWord() % 32'd7);
            sendOp(OpCode'(3'(4 + (r % 4))), randWord(), randWord() >> 16, 1'b0, '0);
            for (int i = 0; i < 3; i++) randMulOp(1'b0, '0);
            randMulOp(1'b1, br);
            drain();
        end

        repeat (mulLatency + 2) @(posedge clk);
        if (!busy && killedCnt > 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("The divider stayed busy at the end, or no branch ever killed an item");
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

endmodule

/* sim/mulDivUnit_asserts.sv */
`timescale 1ns/1ps

module mulDivUnit_asserts import execPkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  en,
    input logic  inValid,
    input OpCode inOp,
    input logic  branchTaken,
    input logic  busy,
    input logic  mulStart,
    input logic  outValid
);

    logic [3:0] sinceBranch;  // Cycles since the last taken branch
    logic       recentBranch;

    always_ff @(posedge clk) begin
        if (!rst) begin
            sinceBranch <= '1;
        end else if (branchTaken) begin
            sinceBranch <= '0;
        end else if (sinceBranch != '1) begin
            sinceBranch <= sinceBranch + 1'b1;
        end
    end

    assign recentBranch = (sinceBranch <= 4'(mulLatency));

    ////////////////////////////////////////////////////////////
    // Properties
    ////////////////////////////////////////////////////////////

    aOutIdleAfterReset: assert property (@(posedge clk) !rst |=> !outValid)
        else $error("outValid high after reset");

    aNoDivWhileBusy: assert property (@(posedge clk) (rst && en && inValid && inOp[2]) |-> !busy)
        else $error("divide offered while busy");

    // mulStart trails the accepting edge by one cycle
    aMulLatency: assert property (@(posedge clk)
        (rst && mulStart) |-> ##(mulLatency) (outValid || recentBranch))
        else $error("multiply result late or missing");

endmodule

/* sim/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst
);

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period

    initial begin
        rst = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

/* src/mulDivUnit.sv */
`timescale 1ns/1ps

module mulDivUnit import execPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  en,
    input  logic  inValid,
    input  OpCode inOp,
    input  Word   srcA,
    input  Word   srcB,
    input  Tag    inTag,
    input  SqN    inSqN,
    input  logic  branchTaken,
    input  SqN    branchSqN,
    output logic  busy,
    output logic  outValid,
    output Tag    outTag,
    output SqN    outSqN,
    output Word   outResult
);

    // Issue bus shared by both datapaths
    logic  mulStart;
    logic  divStart;
    OpCode issueOp;
    Word   issueA;
    Word   issueB;
    Tag    issueTag;
    SqN    issueSqN;

    logic  mulValid;
    Tag    mulTag;
    SqN    mulSqN;
    Word   mulResult;

    logic  divValid;
    Tag    divTag;
    SqN    divSqN;
    Word   divResult;
    logic  divBusy;
    logic  divAck;

    execControl i_execControl (
        .clk, .rst, .en, .inValid, .inOp, .srcA, .srcB, .inTag, .inSqN,
        .branchTaken, .branchSqN,
        .mulValid, .mulTag, .mulSqN, .mulResult,
        .divValid, .divTag, .divSqN, .divResult, .divBusy,
        .busy, .mulStart, .divStart,
        .issueOp, .issueA, .issueB, .issueTag, .issueSqN,
        .divAck, .outValid, .outTag, .outSqN, .outResult
    );

    mulPipe i_mulPipe (
        .clk, .rst, .mulStart,
        .issueOp, .issueA, .issueB, .issueTag, .issueSqN,
        .branchTaken, .branchSqN,
        .mulValid, .mulTag, .mulSqN, .mulResult
    );

    divIter i_divIter (
        .clk, .rst, .divStart,
        .issueOp, .issueA, .issueB, .issueTag, .issueSqN,
        .divAck, .branchTaken, .branchSqN,
        .divBusy, .divValid, .divTag, .divSqN, .divResult
    );

endmodule

/* src/execControl.sv */
`timescale 1ns/1ps

module execControl import execPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  en,
    input  logic  inValid,
    input  OpCode inOp,
    input  Word   srcA,
    input  Word   srcB,
    input  Tag    inTag,
    input  SqN    inSqN,
    input  logic  branchTaken,
    input  SqN    branchSqN,
    input  logic  mulValid,
    input  Tag    mulTag,
    input  SqN    mulSqN,
    input  Word   mulResult,
    input  logic  divValid,
    input  Tag    divTag,
    input  SqN    divSqN,
    input  Word   divResult,
    input  logic  divBusy,
    output logic  busy,
    output logic  mulStart,
    output logic  divStart,
    output OpCode issueOp,
    output Word   issueA,
    output Word   issueB,
    output Tag    issueTag,
    output SqN    issueSqN,
    output logic  divAck,
    output logic  outValid,
    output Tag    outTag,
    output SqN    outSqN,
    output Word   outResult
);

    logic isDiv;
    logic accept;

    ////////////////////////////////////////////////////////////
    // Issue
    ////////////////////////////////////////////////////////////

    assign isDiv  = inOp[2];
    assign accept = en && inValid
        && !isKilled(branchTaken, inSqN, branchSqN)
        && !(isDiv && divBusy);  // Divider holds one op
    assign busy   = divBusy;

    always_ff @(posedge clk) begin
        if (!rst) begin
            mulStart <= 1'b0;
            divStart <= 1'b0;
        end else begin
            mulStart <= accept && !isDiv;
            divStart <= accept && isDiv;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issueOp  <= inOp;
            issueA   <= srcA;
            issueB   <= srcB;
            issueTag <= inTag;
            issueSqN <= inSqN;
        end
    end

    ////////////////////////////////////////////////////////////
    // Writeback merge
    ////////////////////////////////////////////////////////////

    // Multiplier cannot stall, so divide waits for a free slot
    assign divAck = divValid && !mulValid;

    always_ff @(posedge clk) begin
        if (!rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= mulValid || divValid;
        end
    end

    always_ff @(posedge clk) begin
        if (mulValid) begin
            outTag    <= mulTag;
            outSqN    <= mulSqN;
            outResult <= mulResult;
        end else begin
            outTag    <= divTag;
            outSqN    <= divSqN;
            outResult <= divResult;
        end
    end

endmodule

/* src/divIter.sv */
`timescale 1ns/1ps

module divIter import execPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  divStart,
    input  OpCode issueOp,
    input  Word   issueA,
    input  Word   issueB,
    input  Tag    issueTag,
    input  SqN    issueSqN,
    input  logic  divAck,
    input  logic  branchTaken,
    input  SqN    branchSqN,
    output logic  divBusy,
    output logic  divValid,
    output Tag    divTag,
    output SqN    divSqN,
    output Word   divResult
);

    typedef enum logic [1:0] {
        Idle,
        Run,
        Fix,
        Done
    } DivState;

    DivState               state;
    logic [divCntBits-1:0] stepCnt;
    Word                   remReg;
    Word                   quoReg;
    Word                   divisorReg;
    logic                  negQ;
    logic                  negR;
    logic                  wantRem;
    logic                  divZero;

    logic        isSigned;
    logic [32:0] shifted;
    logic [33:0] diff;

    assign isSigned = (issueOp == DivDiv) || (issueOp == DivRem);

    // Start counts as busy so a second divide is refused at once
    assign divBusy = divStart || (state != Idle);

    ////////////////////////////////////////////////////////////
    // Restoring step
    ////////////////////////////////////////////////////////////

    always_comb begin
        shifted = {remReg, quoReg[31]};
        diff    = {1'b0, shifted} - {2'b0, divisorReg};
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= Idle;
            divValid <= 1'b0;
        end else if (state != Idle && isKilled(branchTaken, divSqN, branchSqN)) begin
            state    <= Idle;  // Abandoned
            divValid <= 1'b0;
        end else begin
            case (state)
                Idle: if (divStart && !isKilled(branchTaken, issueSqN, branchSqN)) begin
                    state <= Run;
                end
                Run: if (stepCnt == divCntBits'(divSteps - 1)) begin
                    state <= Fix;
                end
                Fix: begin
                    state    <= Done;
                    divValid <= 1'b1;
                end
                Done: if (divAck) begin
                    state    <= Idle;
                    divValid <= 1'b0;
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            Idle: begin
                remReg     <= '0;
                quoReg     <= (isSigned && issueA[31]) ? -issueA : issueA;
                divisorReg <= (isSigned && issueB[31]) ? -issueB : issueB;
                negQ       <= isSigned && (issueA[31] ^ issueB[31]);
                negR       <= isSigned && issueA[31];  // Remainder follows dividend
                wantRem    <= issueOp[1];
                divZero    <= (issueB == '0);
                divTag     <= issueTag;
                divSqN     <= issueSqN;
                stepCnt    <= '0;
            end
            Run: begin
                stepCnt <= stepCnt + 1'b1;
                if (!diff[33]) begin
                    remReg <= diff[31:0];
                    quoReg <= {quoReg[30:0], 1'b1};
                end else begin
                    remReg <= shifted[31:0];
                    quoReg <= {quoReg[30:0], 1'b0};
                end
            end
            Fix: begin
                // -2^31 / -1 falls out as quotient 0x8000_0000, remainder 0
                if (wantRem) begin
                    divResult <= negR ? -remReg : remReg;
                end else if (divZero) begin
                    divResult <= '1;
                end else begin
                    divResult <= negQ ? -quoReg : quoReg;
                end
            end
            default: ;  // Result held until ack
        endcase
    end

endmodule

/* src/mulPipe.sv */
`timescale 1ns/1ps

module mulPipe import execPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  mulStart,
    input  OpCode issueOp,
    input  Word   issueA,
    input  Word   issueB,
    input  Tag    issueTag,
    input  SqN    issueSqN,
    input  logic  branchTaken,
    input  SqN    branchSqN,
    output logic  mulValid,
    output Tag    mulTag,
    output SqN    mulSqN,
    output Word   mulResult
);

    // Pipeline registers, index 0 is the operand stage
    logic        plValid [mulStages:0];
    Word         plA     [mulStages-1:0];
    Word         plB     [mulStages-1:0];
    logic [63:0] plRes   [mulStages:1];
    logic        plInv   [mulStages:0];
    logic        plHigh  [mulStages:0];
    Tag          plTag   [mulStages:0];
    SqN          plSqN   [mulStages:0];

    logic negA;
    logic negB;

    ////////////////////////////////////////////////////////////
    // Operand conditioning
    ////////////////////////////////////////////////////////////

    always_comb begin
        negA = 1'b0;
        negB = 1'b0;
        case (issueOp)
            MulMulh: begin
                negA = issueA[31];
                negB = issueB[31];
            end
            MulMulsu: negA = issueA[31];  // Only srcA is signed
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            plValid[0] <= 1'b0;
        end else begin
            plValid[0] <= mulStart && !isKilled(branchTaken, issueSqN, branchSqN);
        end
    end

    always_ff @(posedge clk) begin
        plA[0]    <= negA ? -issueA : issueA;
        plB[0]    <= negB ? -issueB : issueB;
        plInv[0]  <= negA ^ negB;
        plHigh[0] <= (issueOp != MulMul);
        plTag[0]  <= issueTag;
        plSqN[0]  <= issueSqN;
    end

    ////////////////////////////////////////////////////////////
    // Partial-product stages
    ////////////////////////////////////////////////////////////

    for (genvar s = 0; s < mulStages; s++) begin : gStage
        logic [63:0] part;  // Slice product shifted into place

        assign part = (64'(plA[s]) * 64'(plB[s][mulSlice*s +: mulSlice])) << (mulSlice*s);

        always_ff @(posedge clk) begin
            if (!rst) begin
                plValid[s+1] <= 1'b0;
            end else begin
                plValid[s+1] <= plValid[s] && !isKilled(branchTaken, plSqN[s], branchSqN);
            end
        end

        always_ff @(posedge clk) begin
            plInv[s+1]  <= plInv[s];
            plHigh[s+1] <= plHigh[s];
            plTag[s+1]  <= plTag[s];
            plSqN[s+1]  <= plSqN[s];
        end

        if (s == 0) begin : gFirst
            always_ff @(posedge clk) begin
                plRes[s+1] <= part;
            end
        end else begin : gAcc
            always_ff @(posedge clk) begin
                plRes[s+1] <= plRes[s] + part;
            end
        end

        if (s < mulStages - 1) begin : gPass
            always_ff @(posedge clk) begin
                plA[s+1] <= plA[s];
                plB[s+1] <= plB[s];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            mulValid <= 1'b0;
        end else begin
            mulValid <= plValid[mulStages]
                && !isKilled(branchTaken, plSqN[mulStages], branchSqN);
        end
    end

    always_ff @(posedge clk) begin
        mulTag <= plTag[mulStages];
        mulSqN <= plSqN[mulStages];
        if (!plHigh[mulStages]) begin
            mulResult <= plRes[mulStages][31:0];  // Same for signed and unsigned
        end else if (plInv[mulStages]) begin
            // High word of the negated 64-bit product
            mulResult <= ~plRes[mulStages][63:32]
                + Word'(plRes[mulStages][31:0] == '0);
        end else begin
            mulResult <= plRes[mulStages][63:32];
        end
    end

endmodule

/* src/execPkg.sv */
package execPkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int wordBits = 32;
    localparam int tagBits  = 6;
    localparam int sqnBits  = 7;

    ////////////////////////////////////////////////////////////
    // Latencies
    ////////////////////////////////////////////////////////////

    localparam int mulStages   = 2;                     // Partial-product stages
    localparam int mulSlice    = wordBits / mulStages;  // Bits of srcB per stage
    localparam int mulLatency  = mulStages + 3;         // Accept edge to outValid
    localparam int divSteps    = 32;                    // One quotient bit each
    localparam int divCntBits  = $clog2(divSteps);

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    // Top bit set means divider
    typedef enum logic [2:0] {
        MulMul   = 3'b000,
        MulMulh  = 3'b001,
        MulMulsu = 3'b010,
        MulMulu  = 3'b011,
        DivDiv   = 3'b100,
        DivDivu  = 3'b101,
        DivRem   = 3'b110,
        DivRemu  = 3'b111
    } OpCode;

    typedef logic [tagBits-1:0]  Tag;
    typedef logic [sqnBits-1:0]  SqN;
    typedef logic [wordBits-1:0] Word;

    // Item is younger than a taken branch
    function automatic logic isKilled(
        input logic taken,
        input SqN   itemSqN,
        input SqN   brSqN
    );
        SqN diff;
        diff = itemSqN - brSqN;  // Wraps, so age is the signed difference
        return taken && ($signed(diff) > 0);
    endfunction

endpackage
